/* logic/fdc_pkg.sv */
// Shared types and constants for the simplified floppy controller
// Port offsets are relative to the 0x3F0 base
// Opcodes not listed in fdc_cmd_e are treated as invalid and dropped
package fdc_pkg;

    // Host port offsets
    typedef enum logic [2:0] {
        PORT_DOR  = 3'h2,
        PORT_MSR  = 3'h4,
        PORT_DATA = 3'h5,
        PORT_DIR  = 3'h7
    } io_port_e;

    // Low five bits of the command byte
    typedef enum logic [4:0] {
        CMD_SPECIFY     = 5'h03,
        CMD_READ_DATA   = 5'h06,
        CMD_RECALIBRATE = 5'h07,
        CMD_SENSE_INT   = 5'h08,
        CMD_SEEK        = 5'h0F,
        CMD_VERSION     = 5'h10
    } fdc_cmd_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PARAMS,
        PH_EXECUTE,
        PH_SEEK,
        PH_READ,
        PH_RESULT
    } fdc_phase_e;

    // Two bits wide to keep the legacy request codes
    typedef enum logic [1:0] {
        REQ_NONE = 2'b00,
        REQ_READ = 2'b01
    } disk_req_e;

    localparam logic [7:0] FDC_VERSION_ID = 8'h90;  // 82077AA
    localparam logic [7:0] SIZE_CODE_512  = 8'd2;
    localparam logic [7:0] ST0_SEEK_END   = 8'h20;
    localparam logic [7:0] ST0_INVALID    = 8'h80;

endpackage

/* logic/fdc_host_regs.sv */
// Host port decode for DOR, MSR, DIR and the data register
// io_readdata is combinational from io_address
// Data reads outside the result phase return 0 and have no side effect
`timescale 1ns/10ps

module fdc_host_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          io_address,
    input  logic                io_read,
    input  logic                io_write,
    input  logic [7:0]          io_writedata,
    output logic [7:0]          io_readdata,
    input  fdc_pkg::fdc_phase_e phase,
    input  logic [7:0]          result_byte,
    input  logic                disk_changed,
    output logic                cmd_wr,
    output logic                res_rd,
    output logic                dma_enable
);
    import fdc_pkg::*;

    logic [7:0] dor;
    logic [7:0] msr;
    logic       rqm;
    logic       dio;
    logic       cb;

    assign rqm = phase inside {PH_IDLE, PH_PARAMS, PH_RESULT};
    assign dio = (phase == PH_RESULT);
    assign cb  = (phase != PH_IDLE);
    assign msr = {rqm, dio, 1'b0, cb, 2'b00, dor[5:4]};  // Motor bits in 1:0

    assign cmd_wr     = io_write && (io_address == PORT_DATA);
    assign res_rd     = io_read && (io_address == PORT_DATA) && (phase == PH_RESULT);
    assign dma_enable = dor[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dor <= 8'h00;
        end else if (io_write && (io_address == PORT_DOR)) begin
            dor <= io_writedata;
        end
    end

    always_comb begin
        case (io_port_e'(io_address))
            PORT_DOR:  io_readdata = dor;
            PORT_MSR:  io_readdata = msr;
            PORT_DATA: io_readdata = (phase == PH_RESULT) ? result_byte : 8'h00;
            PORT_DIR:  io_readdata = {disk_changed, 7'h00};
            default:   io_readdata = 8'hFF;  // Unmapped offsets
        endcase
    end

endmodule

/* logic/fdc_command_seq.sv */
// Command, parameter and result phases of the controller
// Specify bytes are accepted and ignored; unknown opcodes leave it in IDLE
// Data writes during EXECUTE, SEEK, READ and RESULT are ignored
// Result bytes of Read Data carry the final status
`timescale 1ns/10ps

module fdc_command_seq (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_wr,
    input  logic [7:0]          io_writedata,
    input  logic                res_rd,
    output fdc_pkg::fdc_phase_e phase,
    output logic [7:0]          result_byte,
    output logic                irq,
    input  logic [7:0]          current_cyl,
    output fdc_pkg::disk_req_e  request,
    output logic [7:0]          cylinder,
    output logic [7:0]          head,
    output logic [7:0]          sector,
    output logic [7:0]          sector_count,
    output logic [7:0]          drive,
    output logic                seek_start,
    output logic                seek_recal,
    output logic [1:0]          seek_drive,
    input  logic                seek_done,
    input  logic                int_pending,
    input  logic [7:0]          int_st0,
    output logic                int_clear,
    output logic                xfer_start,
    input  logic                xfer_done
);
    import fdc_pkg::*;

    fdc_cmd_e   opcode;
    logic [3:0] param_cnt;
    logic [3:0] param_idx;
    logic [3:0] new_cnt;     // Parameter count of the incoming opcode
    logic       op_known;
    logic [2:0] res_cnt;
    logic [2:0] res_idx;
    logic [7:0] params [0:7];
    logic [7:0] results [0:6];

    always_comb begin
        case (fdc_cmd_e'(io_writedata[4:0]))
            CMD_READ_DATA:   new_cnt = 4'd8;
            CMD_SEEK,
            CMD_SPECIFY:     new_cnt = 4'd2;
            CMD_RECALIBRATE: new_cnt = 4'd1;
            default:         new_cnt = 4'd0;
        endcase
    end

    assign op_known = (new_cnt != 4'd0) || (io_writedata[4:0] == CMD_VERSION)
                      || (io_writedata[4:0] == CMD_SENSE_INT);

    assign seek_recal  = (opcode == CMD_RECALIBRATE);
    assign seek_drive  = params[0][1:0];
    assign int_clear   = (phase == PH_EXECUTE) && (opcode == CMD_SENSE_INT) && int_pending;
    assign result_byte = results[res_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= PH_IDLE;
            opcode       <= CMD_VERSION;
            param_cnt    <= '0;
            param_idx    <= '0;
            res_cnt      <= '0;
            res_idx      <= '0;
            irq          <= 1'b0;
            request      <= REQ_NONE;
            cylinder     <= '0;
            head         <= '0;
            sector       <= '0;
            sector_count <= '0;
            drive        <= '0;
            seek_start   <= 1'b0;
            xfer_start   <= 1'b0;
        end else begin
            seek_start <= 1'b0;
            xfer_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (cmd_wr) begin
                        opcode    <= fdc_cmd_e'(io_writedata[4:0]);
                        param_cnt <= new_cnt;
                        param_idx <= '0;
                        if (new_cnt != 4'd0) begin
                            phase <= PH_PARAMS;
                        end else if (op_known) begin
                            phase <= PH_EXECUTE;
                        end
                    end
                end
                PH_PARAMS: begin
                    if (cmd_wr) begin
                        param_idx <= param_idx + 4'd1;
                        if (param_idx + 4'd1 == param_cnt) begin
                            phase <= PH_EXECUTE;
                        end
                    end
                end
                PH_EXECUTE: begin
                    res_idx <= '0;
                    case (opcode)
                        CMD_VERSION: begin
                            res_cnt <= 3'd1;
                            phase   <= PH_RESULT;
                        end
                        CMD_SENSE_INT: begin
                            res_cnt <= 3'd2;
                            phase   <= PH_RESULT;
                        end
                        CMD_SEEK, CMD_RECALIBRATE: begin
                            drive <= {6'd0, params[0][1:0]};
                            if (opcode == CMD_SEEK) begin
                                head     <= {7'd0, params[0][2]};
                                cylinder <= params[1];
                            end else begin
                                cylinder <= '0;  // Track 0
                            end
                            seek_start <= 1'b1;
                            phase      <= PH_SEEK;
                        end
                        CMD_READ_DATA: begin
                            drive        <= {6'd0, params[0][1:0]};
                            head         <= {7'd0, params[0][2]};
                            cylinder     <= params[1];
                            sector       <= params[3];
                            sector_count <= params[5];
                            request      <= REQ_READ;
                            xfer_start   <= 1'b1;
                            phase        <= PH_READ;
                        end
                        default: phase <= PH_IDLE;  // Specify
                    endcase
                end
                PH_SEEK: begin
                    if (seek_done) begin
                        irq   <= 1'b1;
                        phase <= PH_IDLE;
                    end
                end
                PH_READ: begin
                    if (xfer_done) begin
                        request <= REQ_NONE;
                        res_cnt <= 3'd7;
                        irq     <= 1'b1;
                        phase   <= PH_RESULT;
                    end
                end
                PH_RESULT: begin
                    if (res_rd) begin
                        if (res_idx == res_cnt - 3'd1) begin
                            irq   <= 1'b0;  // Last byte taken
                            phase <= PH_IDLE;
                        end else begin
                            res_idx <= res_idx + 3'd1;
                        end
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_PARAMS && cmd_wr) begin
            params[param_idx[2:0]] <= io_writedata;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_EXECUTE && opcode == CMD_VERSION) begin
            results[0] <= FDC_VERSION_ID;
        end else if (phase == PH_EXECUTE && opcode == CMD_SENSE_INT) begin
            results[0] <= int_pending ? int_st0 : ST0_INVALID;
            results[1] <= int_pending ? current_cyl : 8'h00;
        end else if (phase == PH_READ && xfer_done) begin
            results[0] <= {5'd0, params[0][2:0]};  // Head and drive
            results[1] <= 8'h00;
            results[2] <= 8'h00;
            results[3] <= params[1];
            results[4] <= {7'd0, params[0][2]};
            results[5] <= params[3] + params[5];   // Sector after the last one read
            results[6] <= SIZE_CODE_512;
        end
    end

endmodule

/* logic/fdc_seek_ctrl.sv */
// Head movement delay for Seek and Recalibrate
// The delay is a fixed cycle count, independent of the distance moved
// A new seek before Sense Interrupt overwrites the stored ST0
`timescale 1ns/10ps

module fdc_seek_ctrl #(
    parameter int SEEK_CYCLES  = 500,
    parameter int RECAL_CYCLES = 1000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       seek_start,
    input  logic       seek_recal,
    input  logic [1:0] seek_drive,
    output logic       seek_done,
    output logic       int_pending,
    output logic [7:0] int_st0,
    input  logic       int_clear
);
    import fdc_pkg::*;

    localparam int MAX_CYCLES = (SEEK_CYCLES > RECAL_CYCLES) ? SEEK_CYCLES : RECAL_CYCLES;
    localparam int CW = $clog2(MAX_CYCLES + 1);

    logic [CW-1:0] count;
    logic          busy;
    logic [1:0]    drive_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count       <= '0;
            busy        <= 1'b0;
            drive_q     <= '0;
            seek_done   <= 1'b0;
            int_pending <= 1'b0;
            int_st0     <= '0;
        end else begin
            seek_done <= 1'b0;
            if (int_clear) begin
                int_pending <= 1'b0;
            end
            if (seek_start) begin
                busy    <= 1'b1;
                count   <= seek_recal ? CW'(RECAL_CYCLES) : CW'(SEEK_CYCLES);
                drive_q <= seek_drive;
            end else if (busy) begin
                if (count == '0) begin
                    busy        <= 1'b0;
                    seek_done   <= 1'b1;
                    int_pending <= 1'b1;
                    int_st0     <= ST0_SEEK_END | {6'd0, drive_q};
                end else begin
                    count <= count - CW'(1);
                end
            end
        end
    end

endmodule

/* logic/fdc_sector_reader.sv */
// Byte and sector counting for Read Data
// Disk reads stall while the buffer is full
// xfer_done waits until the buffer has drained to DMA
// SECTOR_BYTES must be at least 2
`timescale 1ns/10ps

module fdc_sector_reader #(
    parameter int SECTOR_BYTES = 512
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       xfer_start,
    input  logic [7:0] sector_count,
    input  logic       disk_ready,
    output logic       disk_data_rd,
    input  logic       fifo_full,
    input  logic       fifo_empty,
    output logic       xfer_done,
    input  logic       dma_enable,
    input  logic       dma_ack,
    output logic       dma_req,
    output logic       pop
);
    localparam int BW = $clog2(SECTOR_BYTES);

    logic [BW-1:0] byte_cnt;      // Position within the current sector
    logic [7:0]    sectors_left;
    logic          active;

    assign disk_data_rd = active && (sectors_left != 8'd0) && disk_ready && !fifo_full;
    assign dma_req      = active && dma_enable && !fifo_empty;
    assign pop          = dma_req && dma_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt     <= '0;
            sectors_left <= '0;
            active       <= 1'b0;
            xfer_done    <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            if (xfer_start) begin
                active       <= 1'b1;
                sectors_left <= sector_count;
                byte_cnt     <= '0;
            end else if (active) begin
                if (disk_data_rd) begin
                    if (byte_cnt == BW'(SECTOR_BYTES - 1)) begin
                        byte_cnt     <= '0;
                        sectors_left <= sectors_left - 8'd1;
                    end else begin
                        byte_cnt <= byte_cnt + BW'(1);
                    end
                end else if (sectors_left == 8'd0 && fifo_empty) begin
                    active    <= 1'b0;  // All read and drained
                    xfer_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/fdc_fifo.sv */
// Sector data buffer between the disk and the DMA channel
// Push when full and pop when empty are ignored
// pop_data shows the head entry at all times
`timescale 1ns/10ps

module fdc_fifo #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       empty,
    output logic       full
);
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

    logic [7:0]    mem [0:FIFO_DEPTH-1];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + AW'(1);
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == FULL_COUNT);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

/* logic/fdc_top.sv */
// Simplified 765/82077 style floppy controller, host port view
// Commands: Version, Specify, Seek, Recalibrate, Sense Interrupt, Read Data
// Read Data bytes flow disk to buffer to DMA; dma_req acts as valid, dma_ack as ready
// disk_ready acts as valid on the disk side, answered by disk_data_rd
`timescale 1ns/10ps

module fdc_top #(
    parameter int SECTOR_BYTES = 512,
    parameter int FIFO_DEPTH   = 512,
    parameter int SEEK_CYCLES  = 500,
    parameter int RECAL_CYCLES = 1000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [2:0]         io_address,
    input  logic               io_read,
    input  logic               io_write,
    input  logic [7:0]         io_writedata,
    output logic [7:0]         io_readdata,
    output logic               dma_req,
    input  logic               dma_ack,
    output logic [7:0]         dma_writedata,
    output logic               irq,
    output fdc_pkg::disk_req_e request,
    output logic [7:0]         cylinder,
    output logic [7:0]         head,
    output logic [7:0]         sector,
    output logic [7:0]         sector_count,
    output logic [7:0]         drive,
    input  logic               disk_ready,
    input  logic [7:0]         disk_data_in,
    output logic               disk_data_rd,
    input  logic               disk_changed,
    input  logic [7:0]         current_cyl
);
    import fdc_pkg::*;

    fdc_phase_e phase;
    logic [7:0] result_byte;
    logic       cmd_wr;
    logic       res_rd;
    logic       dma_enable;
    logic       seek_start;
    logic       seek_recal;
    logic [1:0] seek_drive;
    logic       seek_done;
    logic       int_pending;
    logic [7:0] int_st0;
    logic       int_clear;
    logic       xfer_start;
    logic       xfer_done;
    logic       fifo_full;
    logic       fifo_empty;
    logic       pop;

    fdc_host_regs host_regs_i (.*);

    fdc_command_seq command_seq_i (.*);

    fdc_seek_ctrl #(
        .SEEK_CYCLES (SEEK_CYCLES),
        .RECAL_CYCLES(RECAL_CYCLES)
    ) seek_ctrl_i (.*);

    fdc_sector_reader #(
        .SECTOR_BYTES(SECTOR_BYTES)
    ) sector_reader_i (.*);

    fdc_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (disk_data_rd),
        .push_data(disk_data_in),
        .pop      (pop),
        .pop_data (dma_writedata),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

endmodule

/* dv/fdc_asserts.sv */
// Concurrent checks bound onto the controller top level
// Sampled on the rising clock edge
// Buffer occupancy is rebuilt from the disk push and DMA pop handshakes
// failures counts every assertion that fired
`timescale 1ns/10ps

module fdc_asserts #(
    parameter int FIFO_DEPTH = 512
) (
    input logic clk,
    input logic rst_n,
    input logic dma_req,
    input logic dma_ack,
    input logic disk_ready,
    input logic disk_data_rd,
    input logic irq
);

    int failures = 0;
    int level;  // Bytes held in the buffer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= 0;
        end else begin
            level <= level + (disk_data_rd ? 1 : 0) - ((dma_req && dma_ack) ? 1 : 0);
        end
    end

    // DMA request only with data in the buffer
    dma_req_has_data: assert property (
        @(posedge clk) disable iff (!rst_n) dma_req |-> (level != 0)
    ) else begin
        failures++;
        $error("dma_req high while the buffer is empty");
    end

    disk_rd_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        disk_data_rd |-> (disk_ready && (level < FIFO_DEPTH))
    ) else begin
        failures++;
        $error("disk_data_rd high without disk_ready or without buffer space");
    end

    irq_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !irq  // First cycle out of reset
    ) else begin
        failures++;
        $error("irq high in the cycle after reset release");
    end

endmodule

/* dv/fdc_tb.sv */
// Directed testbench for the floppy controller top level
// Small sector, buffer and seek sizes keep the run short
// Disk and DMA handshakes are randomized from one xorshift stream, seed 43
// Results are sampled on the falling clock edge
`timescale 1ns/10ps

module fdc_tb;
    import fdc_pkg::*;

    localparam int SECTOR_BYTES    = 16;
    localparam int FIFO_DEPTH      = 8;
    localparam int SEEK_CYCLES     = 20;
    localparam int RECAL_CYCLES    = 40;
    localparam int READ_SECTORS    = 3;
    localparam int READ_BYTES      = READ_SECTORS * SECTOR_BYTES;
    localparam int HOST_CYCLES     = 1000;  // Margin for register traffic
    localparam int WATCHDOG_CYCLES = SEEK_CYCLES + RECAL_CYCLES + READ_BYTES * 20 + HOST_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n;
    logic [2:0] io_address;
    logic       io_read;
    logic       io_write;
    logic [7:0] io_writedata;
    logic [7:0] io_readdata;
    logic       dma_req;
    logic       dma_ack;
    logic [7:0] dma_writedata;
    logic       irq;
    disk_req_e  request;
    logic [7:0] cylinder;
    logic [7:0] head;
    logic [7:0] sector;
    logic [7:0] sector_count;
    logic [7:0] drive;
    logic       disk_ready;
    logic [7:0] disk_data_in;
    logic       disk_data_rd;
    logic       disk_changed;
    logic [7:0] current_cyl;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng;
    logic [7:0]  dor_shadow;
    logic [7:0]  cmd_params [0:7];
    logic [7:0]  exp_results [0:6];
    logic [7:0]  disk_bytes [$];   // Bytes the controller took from the disk
    logic [7:0]  dma_bytes [$];    // Bytes handed over on the DMA side
    logic        saw_full = 1'b0;

    fdc_top #(
        .SECTOR_BYTES(SECTOR_BYTES),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SEEK_CYCLES (SEEK_CYCLES),
        .RECAL_CYCLES(RECAL_CYCLES)
    ) dut_i (.*);

    bind fdc_top fdc_asserts #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) asserts_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dma_req     (dma_req),
        .dma_ack     (dma_ack),
        .disk_ready  (disk_ready),
        .disk_data_rd(disk_data_rd),
        .irq         (irq)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // RQM bit 7, DIO bit 6, CB bit 4, motor bits from the last DOR write
    function automatic logic [7:0] expect_msr(input logic rqm, input logic dio, input logic cb);
        return (rqm ? 8'h80 : 8'h00) | (dio ? 8'h40 : 8'h00) | (cb ? 8'h10 : 8'h00)
               | {6'd0, dor_shadow[5:4]};
    endfunction

    // Disk and DMA models share one random stream
    always @(posedge clk) begin
        rng = xorshift(rng);
        if (disk_data_rd) begin
            disk_bytes.push_back(disk_data_in);
            disk_data_in <= rng[7:0];
        end
        if (dma_req && dma_ack) begin
            dma_bytes.push_back(dma_writedata);
        end
        if (dut_i.fifo_full) begin
            saw_full <= 1'b1;
        end
        disk_ready <= (rng[9:8] != 2'b00);    // Ready three cycles in four
        dma_ack    <= (rng[13:12] == 2'b00);  // Slow consumer
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_phase(input fdc_phase_e got, input fdc_phase_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] phase: got 0x%0h (%s), expected 0x%0h (%s)",
                     got, got.name(), exp, exp.name());
        end
    endtask

    task automatic check_request(input disk_req_e got, input disk_req_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] request: got 0x%0h (%s), expected 0x%0h (%s)",
                     got, got.name(), exp, exp.name());
        end
    endtask

    task automatic host_write(input io_port_e addr, input logic [7:0] data);
        @(posedge clk);
        io_address   <= addr;
        io_writedata <= data;
        io_write     <= 1'b1;
        @(posedge clk);
        io_write <= 1'b0;
    endtask

    task automatic host_read(input io_port_e addr, output logic [7:0] data);
        @(posedge clk);
        io_address <= addr;
        io_read    <= 1'b1;
        @(negedge clk);
        data = io_readdata;
        @(posedge clk);
        io_read <= 1'b0;  // Result index moves on this edge
    endtask

    task automatic issue_cmd(input logic [7:0] opcode, input int n_params);
        int i;
        host_write(PORT_DATA, opcode);
        for (i = 0; i < n_params; i++) begin
            host_write(PORT_DATA, cmd_params[i]);
        end
    endtask

    // Poll MSR until RQM and DIO are both set
    task automatic wait_result(input int max_reads);
        logic [7:0] msr;
        int         n;
        n   = 0;
        msr = 8'h00;
        while (msr[7:6] != 2'b11 && n < max_reads) begin
            host_read(PORT_MSR, msr);
            n++;
        end
        if (msr[7:6] != 2'b11) begin
            errors++;
            $display("result phase not reached after %0d status reads", max_reads);
        end
    endtask

    task automatic collect_results(input int n);
        logic [7:0] rd;
        int         i;
        for (i = 0; i < n; i++) begin
            host_read(PORT_DATA, rd);
            check_byte($sformatf("result[%0d]", i), rd, exp_results[i]);
        end
        @(negedge clk);
        check_bit("irq", irq, 1'b0);  // Falls with the last byte
    endtask

    task automatic wait_irq(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            errors++;
            $display("irq did not rise within %0d cycles", max_cycles);
        end
    endtask

    task automatic test_registers();
        logic [7:0] rd;
        check_bit("irq", irq, 1'b0);
        check_bit("dma_req", dma_req, 1'b0);
        check_bit("disk_data_rd", disk_data_rd, 1'b0);
        check_request(request, REQ_NONE);
        check_phase(dut_i.phase, PH_IDLE);
        host_read(PORT_MSR, rd);
        check_byte("msr", rd, 8'h80);
        dor_shadow = 8'h34;  // Both motors, no DMA
        host_write(PORT_DOR, dor_shadow);
        host_read(PORT_DOR, rd);
        check_byte("dor", rd, dor_shadow);
        host_read(PORT_MSR, rd);
        check_byte("msr", rd, expect_msr(1'b1, 1'b0, 1'b0));
        @(posedge clk);
        disk_changed <= 1'b1;
        host_read(PORT_DIR, rd);
        check_byte("dir", rd, 8'h80);
        @(posedge clk);
        disk_changed <= 1'b0;
        host_read(PORT_DIR, rd);
        check_byte("dir", rd, 8'h00);
    endtask

    task automatic test_simple_cmds();
        logic [7:0] rd;
        issue_cmd(8'(CMD_VERSION), 0);
        wait_result(8);
        host_read(PORT_MSR, rd);
        check_byte("msr", rd, expect_msr(1'b1, 1'b1, 1'b1));
        exp_results[0] = FDC_VERSION_ID;
        collect_results(1);
        cmd_params[0] = 8'hDF;
        cmd_params[1] = 8'h02;
        issue_cmd(8'(CMD_SPECIFY), 2);
        host_read(PORT_MSR, rd);
        check_byte("msr", rd, expect_msr(1'b1, 1'b0, 1'b0));
        check_phase(dut_i.phase, PH_IDLE);
        issue_cmd(8'(CMD_SENSE_INT), 0);  // Nothing pending yet
        wait_result(8);
        exp_results[0] = ST0_INVALID;
        exp_results[1] = 8'h00;
        collect_results(2);
    endtask

    task automatic test_seek(input logic [1:0] drv, input logic [7:0] target);
        logic [7:0] rd;
        @(posedge clk);
        current_cyl <= target;
        cmd_params[0] = {6'd0, drv};
        cmd_params[1] = target;
        issue_cmd(8'(CMD_SEEK), 2);
        @(posedge clk);
        @(negedge clk);
        check_phase(dut_i.phase, PH_SEEK);
        check_byte("cylinder", cylinder, target);
        check_byte("drive", drive, {6'd0, drv});
        host_read(PORT_MSR, rd);
        check_byte("msr", rd, expect_msr(1'b0, 1'b0, 1'b1));
        wait_irq(SEEK_CYCLES + 20);
        issue_cmd(8'(CMD_SENSE_INT), 0);
        wait_result(8);
        @(negedge clk);
        check_bit("irq", irq, 1'b1);
        exp_results[0] = ST0_SEEK_END | {6'd0, drv};
        exp_results[1] = target;
        collect_results(2);
    endtask

    task automatic test_recal(input logic [1:0] drv);
        @(posedge clk);
        current_cyl <= 8'h00;  // Head parked on track 0
        cmd_params[0] = {6'd0, drv};
        issue_cmd(8'(CMD_RECALIBRATE), 1);
        @(posedge clk);
        @(negedge clk);
        check_byte("cylinder", cylinder, 8'h00);
        wait_irq(RECAL_CYCLES + 20);
        issue_cmd(8'(CMD_SENSE_INT), 0);
        wait_result(8);
        exp_results[0] = ST0_SEEK_END | {6'd0, drv};
        exp_results[1] = 8'h00;
        collect_results(2);
    endtask

    task automatic test_read_data();
        int i;
        dor_shadow = 8'h3C;  // Motors plus DMA gate
        host_write(PORT_DOR, dor_shadow);
        cmd_params[0] = {5'd0, 1'b1, 2'd2};  // Head 1, drive 2
        cmd_params[1] = 8'h07;
        cmd_params[2] = 8'h01;
        cmd_params[3] = 8'h04;
        cmd_params[4] = SIZE_CODE_512;
        cmd_params[5] = 8'(READ_SECTORS);
        cmd_params[6] = 8'h1B;
        cmd_params[7] = 8'hFF;
        issue_cmd({3'b010, CMD_READ_DATA}, 8);
        @(posedge clk);
        @(negedge clk);
        check_phase(dut_i.phase, PH_READ);
        check_request(request, REQ_READ);
        check_byte("cylinder", cylinder, cmd_params[1]);
        check_byte("head", head, {7'd0, cmd_params[0][2]});
        check_byte("drive", drive, {6'd0, cmd_params[0][1:0]});
        check_byte("sector", sector, cmd_params[3]);
        check_byte("sector_count", sector_count, cmd_params[5]);
        wait_irq(READ_BYTES * 20);
        check_request(request, REQ_NONE);
        checks++;
        if (disk_bytes.size() != READ_BYTES || dma_bytes.size() != READ_BYTES) begin
            errors++;
            $display("byte count mismatch: disk %0d, dma %0d, expected %0d",
                     disk_bytes.size(), dma_bytes.size(), READ_BYTES);
        end
        for (i = 0; i < disk_bytes.size() && i < dma_bytes.size(); i++) begin
            check_byte("dma_writedata", dma_bytes[i], disk_bytes[i]);
        end
        if (!saw_full) begin
            errors++;
            $display("buffer never filled during Read Data");
        end
        wait_result(8);
        exp_results[0] = {5'd0, cmd_params[0][2:0]};
        exp_results[1] = 8'h00;
        exp_results[2] = 8'h00;
        exp_results[3] = cmd_params[1];
        exp_results[4] = {7'd0, cmd_params[0][2]};
        exp_results[5] = cmd_params[3] + cmd_params[5];
        exp_results[6] = SIZE_CODE_512;
        collect_results(7);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        rng          = xorshift(32'd43);
        rst_n        = 1'b0;
        io_address   = 3'd0;
        io_read      = 1'b0;
        io_write     = 1'b0;
        io_writedata = 8'h00;
        dma_ack      = 1'b0;
        disk_ready   = 1'b0;
        disk_data_in = rng[7:0];
        disk_changed = 1'b0;
        current_cyl  = 8'h00;
        dor_shadow   = 8'h00;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_registers();
        test_simple_cmds();
        test_seek(2'd1, 8'h2A);
        test_recal(2'd3);
        test_read_data();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut_i.asserts_i.failures);
        if (errors == 0 && dut_i.asserts_i.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* Makefile */
VERILATOR ?= verilator
TOP       := fdc_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)
RUNFLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
logic/fdc_pkg.sv
logic/fdc_host_regs.sv
logic/fdc_command_seq.sv
logic/fdc_seek_ctrl.sv
logic/fdc_sector_reader.sv
logic/fdc_fifo.sv
logic/fdc_top.sv
dv/fdc_asserts.sv
dv/fdc_tb.sv
